/* hdl/sdram_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing in clock cycles at 200 MHz, for a CL3 SDR part.
// A build may predefine the guard and every macro itself
// to replace all of these values at once.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// Power-up hold of 100 us with CKE high and NOP
`define SDRAM_T_POWERUP       32'd20000

// 8192 refreshes per 64 ms, rounded down
`define SDRAM_T_REF_INTERVAL  32'd1560

// NOP gaps, tRP = 10 ns, tRC = 45 ns, tMRD = 2 tCK
`define SDRAM_T_RP_NOPS       4'd2
`define SDRAM_T_RC_NOPS       4'd9
`define SDRAM_T_MRD_NOPS      4'd2

// Mode register fields
`define SDRAM_MODE_CAS        3'd3   // CAS latency 3
`define SDRAM_MODE_BL         3'b011 // Burst of 8
`define SDRAM_MODE_BT         1'b0   // Sequential
`define SDRAM_MODE_WB         1'b0   // Programmed burst on writes

`endif

/* hdl/sdram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command word types for a 13-bit address, 4-bank SDR part.
// Encodings are active low, ordered cs_n, ras_n, cas_n, we_n.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sdram_pkg;

    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } sdram_cmd_t;

    localparam sdram_cmd_t CMD_NOP  = 4'b0111;
    localparam sdram_cmd_t CMD_PALL = 4'b0010; // Precharge, needs A10 for all banks
    localparam sdram_cmd_t CMD_REF  = 4'b0001; // Auto-refresh
    localparam sdram_cmd_t CMD_LMR  = 4'b0000; // Load mode register

    // Mode register layout, A12 down to A0
    typedef struct packed {
        logic [2:0] reserved;
        logic       write_burst;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_length;
    } sdram_mode_t;

    // Row word, A10 selects all banks on a precharge
    typedef struct packed {
        logic [1:0] high;
        logic       a10;
        logic [9:0] low;
    } sdram_row_t;

    typedef union packed {
        sdram_mode_t mode;
        sdram_row_t  row;
    } sdram_addr_u;

    typedef struct packed {
        sdram_cmd_t  cmd;
        logic [1:0]  ba;
        sdram_addr_u addr;
    } sdram_bus_t;

    // Idle word offered by a source that is not issuing
    localparam sdram_bus_t BUS_NOP = '{cmd: CMD_NOP, ba: 2'b00, addr: 13'd0};

endpackage

/* hdl/sdram_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Refresh interval timer and NOP gap counter.
// The first period after reset is the power-up wait.
// A due refresh must be acknowledged before the next wrap.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_timer (
    input  logic       clock,
    input  logic       reset,
    input  logic       ref_ack,   // Clears ref_due
    input  logic       gap_clear, // Holds the gap counter at zero
    output logic       ref_due,   // Sticky until acknowledged
    output logic [3:0] gap_count
);

    logic [31:0] interval_cnt;
    logic [31:0] interval_limit;
    logic        powerup_done;
    logic        wrap;

    // Power-up wait first, then the regular refresh period
    assign interval_limit = powerup_done ? `SDRAM_T_REF_INTERVAL : `SDRAM_T_POWERUP;
    assign wrap           = (interval_cnt == interval_limit - 32'd1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            interval_cnt <= 32'd0;
            powerup_done <= 1'b0;
        end else if (wrap) begin
            interval_cnt <= 32'd0; // Restart on the wrap keeps the period exact
            powerup_done <= 1'b1;
        end else begin
            interval_cnt <= interval_cnt + 32'd1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ref_due <= 1'b0;
        end else if (wrap) begin
            ref_due <= 1'b1;
        end else if (ref_ack) begin
            ref_due <= 1'b0;
        end
    end

    // Counts cycles since gap_clear fell, saturates at 15
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            gap_count <= 4'd0;
        end else if (gap_clear) begin
            gap_count <= 4'd0;
        end else if (gap_count != 4'hf) begin
            gap_count <= gap_count + 4'd1;
        end
    end

    // A wrap with the previous refresh still pending means one was lost
    missed_refresh_a: assert property (
        @(posedge clock) disable iff (reset)
        wrap |-> (!ref_due || ref_ack)
    ) else $error("refresh interval elapsed with ref_due still pending");

endmodule

/* hdl/sdram_refresh_fsm.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One precharge-all and auto-refresh pair per enable strobe.
// The enable is only accepted while idle.
// NOP gaps are counted by the shared timer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_refresh_fsm import sdram_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       ref_enable, // Strobe, starts one pair
    input  logic [3:0] gap_count,
    output logic       gap_clear,
    output logic       end_ref,    // Pulse in the last NOP
    output sdram_bus_t cmd_bus
);

    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_pall     = 3'd1;
    localparam logic [2:0] st_pall_nop = 3'd2;
    localparam logic [2:0] st_ref      = 3'd3;
    localparam logic [2:0] st_ref_nop  = 3'd4;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       pall_gap_done;
    logic       ref_gap_done;

    // Gap count is zero in the first NOP after a command
    assign pall_gap_done = (gap_count == `SDRAM_T_RP_NOPS - 4'd1);
    assign ref_gap_done  = (gap_count == `SDRAM_T_RC_NOPS - 4'd1);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        end_ref    = 1'b0;
        gap_clear  = 1'b0;
        cmd_bus    = BUS_NOP;
        case (state)
            st_idle: begin
                gap_clear = 1'b1;
                if (ref_enable) begin
                    next_state = st_pall;
                end
            end
            st_pall: begin
                gap_clear            = 1'b1;
                cmd_bus.cmd          = CMD_PALL;
                cmd_bus.addr.row.a10 = 1'b1; // All banks
                next_state           = st_pall_nop;
            end
            st_pall_nop: begin
                // Wait here until tRP is covered
                if (pall_gap_done) begin
                    next_state = st_ref;
                end
            end
            st_ref: begin
                gap_clear   = 1'b1;
                cmd_bus.cmd = CMD_REF;
                next_state  = st_ref_nop;
            end
            st_ref_nop: begin
                if (ref_gap_done) begin
                    end_ref    = 1'b1;
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // The sequencer must not restart a pair that is still running
    enable_in_idle_a: assert property (
        @(posedge clock) disable iff (reset)
        ref_enable |-> (state == st_idle)
    ) else $error("ref_enable seen outside idle");

endmodule

/* hdl/sdram_maint_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Power-up, init refreshes, mode load, then periodic refresh.
// Refresh interval must be well above one refresh pair.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_maint_seq import sdram_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       ref_due,
    input  logic       end_ref,
    output logic       ref_ack,    // Pulse, clears ref_due
    output logic       ref_enable, // Pulse to the refresh FSM
    output logic       ready,
    output logic       busy,
    output sdram_bus_t cmd_bus
);

    localparam logic [2:0] st_powerup_wait = 3'd0;
    localparam logic [2:0] st_init_ref1    = 3'd1;
    localparam logic [2:0] st_init_ref2    = 3'd2;
    localparam logic [2:0] st_lmr          = 3'd3;
    localparam logic [2:0] st_lmr_nop      = 3'd4;
    localparam logic [2:0] st_run          = 3'd5;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       in_flight; // Refresh FSM is busy with a pair
    logic [3:0] mrd_cnt;
    logic       in_init_ref;

    assign in_init_ref = (state == st_init_ref1) || (state == st_init_ref2);

    // Enable only while the refresh FSM sits in idle
    assign ref_enable = !in_flight && (in_init_ref || ((state == st_run) && ref_due));
    assign ref_ack    = ((state == st_powerup_wait) && ref_due) ||
                        ((state == st_run) && ref_due && !in_flight);
    assign ready      = (state == st_run);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_powerup_wait;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        cmd_bus    = BUS_NOP;
        case (state)
            st_powerup_wait: begin
                if (ref_due) begin
                    next_state = st_init_ref1;
                end
            end
            st_init_ref1: begin
                if (end_ref) begin
                    next_state = st_init_ref2;
                end
            end
            st_init_ref2: begin
                if (end_ref) begin
                    next_state = st_lmr;
                end
            end
            st_lmr: begin
                cmd_bus.cmd                    = CMD_LMR;
                cmd_bus.addr.mode.write_burst  = `SDRAM_MODE_WB;
                cmd_bus.addr.mode.cas_latency  = `SDRAM_MODE_CAS;
                cmd_bus.addr.mode.burst_type   = `SDRAM_MODE_BT;
                cmd_bus.addr.mode.burst_length = `SDRAM_MODE_BL;
                next_state                     = st_lmr_nop;
            end
            st_lmr_nop: begin
                if (mrd_cnt == `SDRAM_T_MRD_NOPS - 4'd1) begin
                    next_state = st_run;
                end
            end
            st_run: begin
                next_state = st_run; // Only reset leaves run
            end
            default: begin
                next_state = st_powerup_wait;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (ref_enable) begin
            in_flight <= 1'b1;
        end else if (end_ref) begin
            in_flight <= 1'b0;
        end
    end

    // tMRD count, restarts outside lmr_nop
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mrd_cnt <= 4'd0;
        end else if (state == st_lmr_nop) begin
            mrd_cnt <= mrd_cnt + 4'd1;
        end else begin
            mrd_cnt <= 4'd0;
        end
    end

    // Busy spans enable through end_ref, one cycle late
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (state == st_run) && (ref_enable || in_flight);
        end
    end

endmodule

/* hdl/sdram_cmd_reg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output register for the SDRAM command pins.
// Only one source may issue a command per cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sdram_cmd_reg import sdram_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  sdram_bus_t seq_bus,
    input  sdram_bus_t ref_bus,
    output sdram_bus_t dram,
    output logic       dram_cke
);

    logic seq_active;
    logic ref_active;

    assign seq_active = (seq_bus.cmd != CMD_NOP);
    assign ref_active = (ref_bus.cmd != CMD_NOP);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dram <= BUS_NOP;
        end else if (seq_active) begin
            dram <= seq_bus;
        end else if (ref_active) begin
            dram <= ref_bus;
        end else begin
            dram <= BUS_NOP;
        end
    end

    // CKE stays high, power-down is left to the host controller
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dram_cke <= 1'b1;
        end else begin
            dram_cke <= 1'b1;
        end
    end

    // Sequencer and refresh FSM take turns on the bus
    one_source_a: assert property (
        @(posedge clock) disable iff (reset)
        !(seq_active && ref_active)
    ) else $error("both command sources active in one cycle");

endmodule

/* hdl/sdram_maint.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDRAM init and refresh keeper, no read or write path.
// Host must hold off its own commands while busy or not ready.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sdram_maint import sdram_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    output logic       ready,
    output logic       busy,
    output logic       dram_cke,
    output sdram_bus_t dram
);

    logic       ref_due;
    logic       ref_ack;
    logic       gap_clear;
    logic [3:0] gap_count;
    logic       ref_enable;
    logic       end_ref;
    sdram_bus_t seq_bus;
    sdram_bus_t ref_bus;

    sdram_timer timer (
        .clock     (clock),
        .reset     (reset),
        .ref_ack   (ref_ack),
        .gap_clear (gap_clear),
        .ref_due   (ref_due),
        .gap_count (gap_count)
    );

    sdram_maint_seq seq (
        .clock      (clock),
        .reset      (reset),
        .ref_due    (ref_due),
        .end_ref    (end_ref),
        .ref_ack    (ref_ack),
        .ref_enable (ref_enable),
        .ready      (ready),
        .busy       (busy),
        .cmd_bus    (seq_bus)
    );

    sdram_refresh_fsm refresh (
        .clock      (clock),
        .reset      (reset),
        .ref_enable (ref_enable),
        .gap_count  (gap_count),
        .gap_clear  (gap_clear),
        .end_ref    (end_ref),
        .cmd_bus    (ref_bus)
    );

    // Pins are registered here
    sdram_cmd_reg cmd_reg (
        .clock    (clock),
        .reset    (reset),
        .seq_bus  (seq_bus),
        .ref_bus  (ref_bus),
        .dram     (dram),
        .dram_cke (dram_cke)
    );

endmodule

/* verification/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 20 ns clock, reset high for the first 8 rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int half_period  = 10;
    localparam int reset_cycles = 8;

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0; // Released on a rising edge
    end

endmodule

/* verification/tb_sdram_maint.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cycle model of the controller pins that restarts on every reset.
// Refresh interval must exceed the init sequence length.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram_maint import sdram_pkg::*; ();

    localparam int t_pu     = int'(`SDRAM_T_POWERUP);
    localparam int t_int    = int'(`SDRAM_T_REF_INTERVAL);
    localparam int rp_nops  = int'(`SDRAM_T_RP_NOPS);
    localparam int rc_nops  = int'(`SDRAM_T_RC_NOPS);
    localparam int mrd_nops = int'(`SDRAM_T_MRD_NOPS);

    // Cycle 0 is the first clock period after reset falls
    localparam int pair_len      = rp_nops + rc_nops + 3; // Enable to idle again
    localparam int init_enable_1 = t_pu + 1;
    localparam int init_enable_2 = init_enable_1 + pair_len;
    localparam int lmr_issue     = init_enable_2 + pair_len;
    localparam int ready_cycle   = lmr_issue + 1 + mrd_nops;
    localparam sdram_bus_t idle_word = '{cmd: CMD_NOP, ba: 2'b00, addr: 13'd0};

    logic       clock;
    logic       por_reset;
    logic       extra_reset;
    logic       reset;
    logic       ready;
    logic       busy;
    logic       dram_cke;
    sdram_bus_t dram;

    int cyc;       // Model cycle counted at falling edges
    int rel_cycle; // Stimulus cycle since the last reset release
    int num_periods;
    int check_count;
    int err_count;
    int check_mark;
    int err_mark;
    int test_count;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (por_reset)
    );

    assign reset = por_reset | extra_reset;

    sdram_maint UUT (
        .clock    (clock),
        .reset    (reset),
        .ready    (ready),
        .busy     (busy),
        .dram_cke (dram_cke),
        .dram     (dram)
    );

    // Refresh pair starts for two init pairs and one per interval
    function automatic logic is_enable(input int k);
        if (k == init_enable_1 || k == init_enable_2) begin
            return 1'b1;
        end
        if (k >= t_pu + t_int && (k - t_pu) % t_int == 0) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic busy_expected(input int k);
        int start;
        if (k - 1 < t_pu + t_int) begin
            return 1'b0;
        end
        start = t_pu + ((k - 1 - t_pu) / t_int) * t_int;
        return (k - start <= pair_len);
    endfunction

    // Pins lag the source by one cycle
    function automatic sdram_bus_t expected_bus(input int k);
        sdram_bus_t word;
        word = idle_word;
        if (is_enable(k - 2)) begin
            word.cmd          = CMD_PALL;
            word.addr.row.a10 = 1'b1;
        end else if (is_enable(k - rp_nops - 3)) begin
            word.cmd = CMD_REF;
        end else if (k == lmr_issue + 1) begin
            word.cmd                    = CMD_LMR;
            word.addr.mode.write_burst  = `SDRAM_MODE_WB;
            word.addr.mode.cas_latency  = `SDRAM_MODE_CAS;
            word.addr.mode.burst_type   = `SDRAM_MODE_BT;
            word.addr.mode.burst_length = `SDRAM_MODE_BL;
        end
        return word;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("Test %0d, %s: %0d checks, %0d errors", test_count, name,
                 check_count - check_mark, err_count - err_mark);
        check_mark = check_count;
        err_mark   = err_count;
    endtask

    task automatic advance_to(input int target);
        while (rel_cycle < target) begin
            @(posedge clock);
            rel_cycle++;
        end
    endtask

    task automatic pulse_reset(input int len);
        extra_reset <= 1'b1;
        repeat (len) @(posedge clock);
        extra_reset <= 1'b0;
        rel_cycle = 0;
    endtask

    // Pins move on rising edges and are sampled on falling ones
    always @(negedge clock) begin : monitor
        sdram_bus_t exp_bus;
        logic       exp_ready;
        logic       exp_busy;
        if (reset) begin
            exp_bus   = idle_word;
            exp_ready = 1'b0;
            exp_busy  = 1'b0;
            cyc       = 0;
        end else begin
            exp_bus   = expected_bus(cyc);
            exp_ready = (cyc >= ready_cycle);
            exp_busy  = busy_expected(cyc);
            cyc       = cyc + 1;
        end
        compare("dram.cmd", {28'd0, dram.cmd}, {28'd0, exp_bus.cmd});
        compare("dram.ba", {30'd0, dram.ba}, {30'd0, exp_bus.ba});
        compare("dram.addr", {19'd0, dram.addr}, {19'd0, exp_bus.addr});
        if (exp_bus.cmd == CMD_PALL) begin
            compare("dram.addr.row.a10", {31'd0, dram.addr.row.a10}, 32'd1);
        end
        compare("dram_cke", {31'd0, dram_cke}, 32'd1);
        compare("ready", {31'd0, ready}, {31'd0, exp_ready});
        compare("busy", {31'd0, busy}, {31'd0, exp_busy});
    end

    initial begin : stimulus
        int target;
        extra_reset = 1'b0;
        void'($urandom(81359));
        num_periods = 2 + int'($urandom % 3);
        if (t_int <= ready_cycle - t_pu) begin
            $display("Refresh interval of %0d cycles is too short for init", t_int);
            err_count++;
        end
        @(negedge por_reset);
        rel_cycle = 0;
        report_test("reset values");
        advance_to(ready_cycle + 2);
        report_test("initialisation and ready");
        advance_to(t_pu + num_periods * t_int + pair_len + 2);
        report_test("periodic refresh and busy");
        // Reset lands between the PALL and end_ref of the next run-mode refresh
        target = t_pu + (num_periods + 1) * t_int + 1 + int'($urandom % (pair_len - 1));
        advance_to(target);
        pulse_reset(1 + int'($urandom % 4));
        // Somewhere from the first init enable to the last mode-load NOP
        target = t_pu + 1 + int'($urandom % (ready_cycle - t_pu - 1));
        advance_to(target);
        report_test("reset during refresh");
        pulse_reset(1 + int'($urandom % 4));
        advance_to(t_pu + num_periods * t_int + pair_len + 2);
        report_test("reset during initialisation");
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Three power-up sequences with their refresh periods and some slack
    initial begin : watchdog
        longint limit;
        @(negedge por_reset);
        limit = 3 * (longint'(t_pu) + longint'(num_periods + 1) * t_int) + 500;
        #(limit * 20);
        $display("Timeout: the tests did not end within %0d clock cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/sdram_pkg.sv
hdl/sdram_timer.sv
hdl/sdram_refresh_fsm.sv
hdl/sdram_maint_seq.sv
hdl/sdram_cmd_reg.sv
hdl/sdram_maint.sv
verification/tb_clock_gen.sv
verification/tb_sdram_maint.sv

/* Makefile */
# Verilator build and run of the SDRAM maintenance controller testbench

VERILATOR   ?= verilator
TOP         ?= tb_sdram_maint
FILE_LIST   ?= verilog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= Simulation passed
VFLAGS      ?= --binary --timing --assert --timescale 1ns/1ps

# Short power-up wait and refresh interval, the header guard keeps these
SIM_DEFINES ?= +define+SDRAM_DEFINES_SVH \
               +define+SDRAM_T_POWERUP=32\'d200 \
               +define+SDRAM_T_REF_INTERVAL=32\'d100 \
               +define+SDRAM_T_RP_NOPS=4\'d2 \
               +define+SDRAM_T_RC_NOPS=4\'d9 \
               +define+SDRAM_T_MRD_NOPS=4\'d2 \
               +define+SDRAM_MODE_CAS=3\'d3 \
               +define+SDRAM_MODE_BL=3\'b011 \
               +define+SDRAM_MODE_BT=1\'b0 \
               +define+SDRAM_MODE_WB=1\'b0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(SIM_BIN): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) $(SIM_DEFINES) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

check:
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
